// File: common/tdc_pkg.sv
`default_nettype none

package tdc_pkg;

	// Command kinds understood by the SPI engine
	typedef enum logic [1:0] {
		TDC_CMD_OP    = 2'd0, // Opcode only
		TDC_CMD_WRITE = 2'd1, // Opcode plus 32-bit word
		TDC_CMD_READ  = 2'd2  // Opcode plus 24-bit readback
	} tdc_cmd_kind_e;

	localparam int TDC_WORD_W  = 32;
	localparam int OPCODE_BITS = 8;
	localparam int WRITE_BITS  = TDC_WORD_W;
	localparam int RESULT_BITS = 24; // Read payload, upper bits of word
	localparam int SEQ_W       = 8;

	localparam logic [OPCODE_BITS-1:0] OP_POWER_ON_RESET = 8'h50;
	localparam logic [OPCODE_BITS-1:0] OP_INIT           = 8'h70;
	localparam logic [OPCODE_BITS-1:0] OP_WRITE_CFG_BASE = 8'h80; // Plus register index
	localparam logic [OPCODE_BITS-1:0] OP_READ_RESULT    = 8'hB0;

	localparam int CFG_REG_COUNT = 3;
	localparam int CFG_ADDR_W    = 2;
	localparam logic [TDC_WORD_W-1:0] CFG_RESET_VALUES [CFG_REG_COUNT] = '{
		32'h0083_4110,
		32'h4200_0000,
		32'h0010_0C35
	};

	localparam int RESULT_FIFO_DEPTH = 4;
	localparam int FIFO_PTR_W        = $clog2(RESULT_FIFO_DEPTH);

	// Engine bit schedule, counted from the cycle after acceptance
	localparam int SPI_GUARD_CYCLES = 6;
	localparam int SPI_CNT_W        = 7;
	localparam logic [SPI_CNT_W-1:0] SPI_SSN_FALL_CNT  = 7'd1;
	localparam logic [SPI_CNT_W-1:0] SPI_FIRST_BIT_CNT = 7'd3;
	localparam logic [SPI_CNT_W-1:0] SPI_RD_FIRST_CNT  =
		SPI_CNT_W'(SPI_FIRST_BIT_CNT + 2 * OPCODE_BITS + 1);

	typedef struct packed {
		tdc_cmd_kind_e          kind;
		logic [OPCODE_BITS-1:0] opcode;
		logic [TDC_WORD_W-1:0]  wdata;
	} tdc_spi_req_t;

	typedef struct packed {
		logic [SEQ_W-1:0]       seq;
		logic [RESULT_BITS-1:0] value;
	} tdc_result_t;

endpackage

`default_nettype wire

// File: tdc_spi/tdc_spi_master.sv
`timescale 1ns/1ps
`default_nettype none

module tdc_spi_master (
	input  wire                            clk,
	input  wire                            i_rst_n,
	input  logic                           req_valid_i,
	input  tdc_pkg::tdc_spi_req_t          req_i,
	output logic                           ack_o,
	output logic                           done_o,
	output logic [tdc_pkg::TDC_WORD_W-1:0] rd_data_o,
	input  wire                            spi_so_i,
	output logic                           spi_sck_o,
	output logic                           spi_ssn_o,
	output logic                           spi_si_o
);
	import tdc_pkg::*;

	typedef enum logic [3:0] {
		ST_IDLE  = 4'b0001,
		ST_FRAME = 4'b0010,
		ST_END   = 4'b0100,
		ST_GUARD = 4'b1000
	} spi_state_e;

	spi_state_e state;
	tdc_cmd_kind_e kind_q;
	logic [SPI_CNT_W-1:0] cnt;
	logic [SPI_CNT_W-1:0] frame_bits;
	logic [SPI_CNT_W-1:0] last_cnt;
	logic [SPI_CNT_W-1:0] ssn_cnt;
	logic [OPCODE_BITS+WRITE_BITS-1:0] tx_shift;
	logic [RESULT_BITS-1:0] rx_shift;
	logic accept;
	logic in_bits;
	logic sample_en;

	assign accept = (state == ST_IDLE) && req_valid_i;

	always_comb begin
		case (kind_q)
			TDC_CMD_WRITE: frame_bits = SPI_CNT_W'(OPCODE_BITS + WRITE_BITS);
			TDC_CMD_READ:  frame_bits = SPI_CNT_W'(OPCODE_BITS + RESULT_BITS);
			default:       frame_bits = SPI_CNT_W'(OPCODE_BITS);
		endcase
	end

	// Last falling SCK count of the frame
	assign last_cnt = SPI_FIRST_BIT_CNT + (frame_bits << 1) - 1'b1;
	// Reads release SSN one count earlier than opcode and write frames
	assign ssn_cnt = (kind_q == TDC_CMD_READ) ? last_cnt + 7'd2 : last_cnt + 7'd3;

	assign in_bits = (state == ST_FRAME) && (cnt >= SPI_FIRST_BIT_CNT) && (cnt <= last_cnt);
	assign sample_en = in_bits && (kind_q == TDC_CMD_READ) && !cnt[0] &&
		(cnt >= SPI_RD_FIRST_CNT);

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state     <= ST_IDLE;
			kind_q    <= TDC_CMD_OP;
			cnt       <= '0;
			ack_o     <= 1'b0;
			done_o    <= 1'b0;
			spi_sck_o <= 1'b0;
			spi_ssn_o <= 1'b1;
			spi_si_o  <= 1'b0;
		end else begin
			ack_o  <= 1'b0;
			done_o <= 1'b0;
			case (state)
				ST_IDLE: begin
					cnt <= '0;
					if (req_valid_i) begin
						kind_q <= req_i.kind;
						ack_o  <= 1'b1;
						state  <= ST_FRAME;
					end
				end
				ST_FRAME: begin
					cnt <= cnt + 1'b1;
					if (cnt == SPI_SSN_FALL_CNT)
						spi_ssn_o <= 1'b0;
					if (in_bits) begin
						if (cnt[0]) begin
							spi_sck_o <= 1'b1; // Rising edge, next bit out
							spi_si_o  <= tx_shift[OPCODE_BITS+WRITE_BITS-1];
						end else begin
							spi_sck_o <= 1'b0; // Slave samples here
						end
					end
					if (cnt == last_cnt + 1'b1)
						spi_si_o <= 1'b0;
					if (cnt == ssn_cnt)
						spi_ssn_o <= 1'b1;
					if (cnt == ssn_cnt + 1'b1) begin
						cnt       <= '0;
						spi_sck_o <= 1'b0;
						state     <= ST_END;
					end
				end
				ST_END: begin
					done_o    <= 1'b1;
					spi_ssn_o <= 1'b1;
					spi_sck_o <= 1'b0;
					spi_si_o  <= 1'b0;
					state     <= ST_GUARD;
				end
				ST_GUARD: begin
					if (cnt == SPI_CNT_W'(SPI_GUARD_CYCLES - 1)) begin
						cnt   <= '0;
						state <= ST_IDLE;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Shift registers, loaded on acceptance
	always_ff @(posedge clk) begin
		if (accept)
			tx_shift <= {req_i.opcode, (req_i.kind == TDC_CMD_WRITE) ? req_i.wdata : '0};
		else if (in_bits && cnt[0])
			tx_shift <= tx_shift << 1;
		if (sample_en)
			rx_shift <= {rx_shift[RESULT_BITS-2:0], spi_so_i};
	end

	assign rd_data_o = {rx_shift, {(TDC_WORD_W - RESULT_BITS){1'b0}}};

	ack_after_accept: assert property (@(posedge clk) disable iff (!i_rst_n)
		ack_o |-> $past(state == ST_IDLE && req_valid_i));

	ssn_high_in_idle: assert property (@(posedge clk) disable iff (!i_rst_n)
		(state == ST_IDLE) |-> spi_ssn_o);

endmodule

`default_nettype wire

// File: design/tdc_cfg_regs.sv
`timescale 1ns/1ps
`default_nettype none

module tdc_cfg_regs (
	input  wire                            clk,
	input  wire                            i_rst_n,
	input  wire                            we_i,
	input  wire  [tdc_pkg::CFG_ADDR_W-1:0] waddr_i,
	input  wire  [tdc_pkg::TDC_WORD_W-1:0] wdata_i,
	input  wire  [tdc_pkg::CFG_ADDR_W-1:0] raddr_i,
	output logic [tdc_pkg::TDC_WORD_W-1:0] rdata_o
);
	import tdc_pkg::*;

	logic [TDC_WORD_W-1:0] regs [CFG_REG_COUNT];

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			for (int i = 0; i < CFG_REG_COUNT; i++)
				regs[i] <= CFG_RESET_VALUES[i];
		end else if (we_i && (waddr_i < CFG_ADDR_W'(CFG_REG_COUNT))) begin
			regs[waddr_i] <= wdata_i; // Unmapped addresses ignored
		end
	end

	assign rdata_o = (raddr_i < CFG_ADDR_W'(CFG_REG_COUNT)) ? regs[raddr_i] : '0;

endmodule

`default_nettype wire

// File: design/tdc_result_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module tdc_result_fifo #(
	parameter type T_ENTRY = tdc_pkg::tdc_result_t
) (
	input  wire    clk,
	input  wire    i_rst_n,
	input  wire    push_i,
	input  T_ENTRY push_data_i,
	input  wire    pop_i,
	output T_ENTRY pop_data_o,
	output logic   not_empty_o,
	output logic   overflow_o
);
	import tdc_pkg::*;

	T_ENTRY mem [RESULT_FIFO_DEPTH];
	logic [FIFO_PTR_W-1:0] wr_ptr;
	logic [FIFO_PTR_W-1:0] rd_ptr;
	logic [FIFO_PTR_W:0] count;
	logic full;
	logic do_push;
	logic do_pop;

	assign full = (count == (FIFO_PTR_W + 1)'(RESULT_FIFO_DEPTH));
	assign not_empty_o = (count != '0);
	assign do_push = push_i && !full; // Full push is dropped
	assign do_pop = pop_i && not_empty_o;

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			count      <= '0;
			overflow_o <= 1'b0;
		end else begin
			if (do_push)
				wr_ptr <= (wr_ptr == FIFO_PTR_W'(RESULT_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == FIFO_PTR_W'(RESULT_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
			if (push_i && full)
				overflow_o <= 1'b1; // Sticky until reset
		end
	end

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= push_data_i;
	end

	assign pop_data_o = mem[rd_ptr]; // First word falls through

	count_in_range: assert property (@(posedge clk) disable iff (!i_rst_n)
		count <= (FIFO_PTR_W + 1)'(RESULT_FIFO_DEPTH));

endmodule

`default_nettype wire

// File: design/tdc_seq_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module tdc_seq_ctrl (
	input  wire                            clk,
	input  wire                            i_rst_n,
	input  wire                            start_i,
	input  wire                            tdc_intn_i,
	output logic                           req_valid_o,
	output tdc_pkg::tdc_spi_req_t          req_o,
	input  wire                            ack_i,
	input  wire                            done_i,
	input  wire  [tdc_pkg::TDC_WORD_W-1:0] rd_data_i,
	output logic [tdc_pkg::CFG_ADDR_W-1:0] cfg_idx_o,
	input  wire  [tdc_pkg::TDC_WORD_W-1:0] cfg_word_i,
	output logic                           push_o,
	output tdc_pkg::tdc_result_t           push_data_o,
	output logic                           busy_o
);
	import tdc_pkg::*;

	typedef enum logic [2:0] {
		S_IDLE,
		S_POR,
		S_CFG,
		S_INIT,
		S_ARMED,
		S_READ
	} seq_state_e;

	seq_state_e st;
	logic in_flight; // Frame acked, done not yet seen
	logic frame_done;
	logic [CFG_ADDR_W-1:0] cfg_idx_q;
	logic [SEQ_W-1:0] seq_q;

	assign frame_done = done_i && in_flight;
	assign cfg_idx_o = cfg_idx_q;

	// Request contents follow the state
	always_comb begin
		req_o.kind   = TDC_CMD_OP;
		req_o.opcode = OP_INIT;
		req_o.wdata  = '0;
		case (st)
			S_POR: req_o.opcode = OP_POWER_ON_RESET;
			S_CFG: begin
				req_o.kind   = TDC_CMD_WRITE;
				req_o.opcode = OP_WRITE_CFG_BASE + OPCODE_BITS'(cfg_idx_q);
				req_o.wdata  = cfg_word_i; // Host value as of acceptance
			end
			S_READ: begin
				req_o.kind   = TDC_CMD_READ;
				req_o.opcode = OP_READ_RESULT;
			end
			default: ;
		endcase
	end

	assign push_o = (st == S_READ) && frame_done;
	assign push_data_o.seq = seq_q;
	assign push_data_o.value = rd_data_i[TDC_WORD_W-1 -: RESULT_BITS];

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			st          <= S_IDLE;
			req_valid_o <= 1'b0;
			in_flight   <= 1'b0;
			cfg_idx_q   <= '0;
			seq_q       <= '0;
			busy_o      <= 1'b0;
		end else begin
			if (ack_i) begin
				req_valid_o <= 1'b0;
				in_flight   <= 1'b1;
			end
			if (done_i)
				in_flight <= 1'b0;
			case (st)
				S_IDLE: if (start_i) begin
					st          <= S_POR;
					req_valid_o <= 1'b1;
					busy_o      <= 1'b1;
				end
				S_POR: if (frame_done) begin
					st          <= S_CFG;
					cfg_idx_q   <= '0;
					req_valid_o <= 1'b1;
				end
				S_CFG: if (frame_done) begin
					req_valid_o <= 1'b1;
					if (cfg_idx_q == CFG_ADDR_W'(CFG_REG_COUNT - 1))
						st <= S_INIT;
					else
						cfg_idx_q <= cfg_idx_q + 1'b1;
				end
				S_INIT: if (frame_done) begin
					st     <= S_ARMED;
					busy_o <= 1'b0; // Chip armed
				end
				S_ARMED: if (!tdc_intn_i) begin
					st          <= S_READ;
					req_valid_o <= 1'b1;
					busy_o      <= 1'b1;
				end
				S_READ: if (frame_done) begin
					st          <= S_INIT; // Re-arm
					seq_q       <= seq_q + 1'b1;
					req_valid_o <= 1'b1;
				end
				default: st <= S_IDLE;
			endcase
		end
	end

	// A new request only once the engine has finished the previous frame
	req_after_done: assert property (@(posedge clk) disable iff (!i_rst_n)
		$rose(req_valid_o) |-> !in_flight);

endmodule

`default_nettype wire

// File: design/tdc_frontend_top.sv
`timescale 1ns/1ps
`default_nettype none

module tdc_frontend_top (
	input  wire                            clk,
	input  wire                            i_rst_n,
	input  wire                            start_i,
	input  wire                            cfg_we_i,
	input  wire  [tdc_pkg::CFG_ADDR_W-1:0] cfg_addr_i,
	input  wire  [tdc_pkg::TDC_WORD_W-1:0] cfg_wdata_i,
	input  wire                            result_pop_i,
	output tdc_pkg::tdc_result_t           result_o,
	output logic                           result_valid_o,
	output logic                           overflow_o,
	output logic                           busy_o,
	output logic                           spi_sck_o,
	output logic                           spi_ssn_o,
	output logic                           spi_si_o,
	input  wire                            spi_so_i,
	input  wire                            tdc_intn_i
);
	import tdc_pkg::*;

	tdc_spi_req_t req;
	tdc_result_t push_data;
	logic req_valid;
	logic ack;
	logic done;
	logic push;
	logic [TDC_WORD_W-1:0] rd_data;
	logic [CFG_ADDR_W-1:0] cfg_idx;
	logic [TDC_WORD_W-1:0] cfg_word;

	tdc_seq_ctrl tdc_seq_ctrl_i (
		.clk         (clk),
		.i_rst_n     (i_rst_n),
		.start_i     (start_i),
		.tdc_intn_i  (tdc_intn_i),
		.req_valid_o (req_valid),
		.req_o       (req),
		.ack_i       (ack),
		.done_i      (done),
		.rd_data_i   (rd_data),
		.cfg_idx_o   (cfg_idx),
		.cfg_word_i  (cfg_word),
		.push_o      (push),
		.push_data_o (push_data),
		.busy_o      (busy_o)
	);

	tdc_spi_master tdc_spi_master_i (
		.clk         (clk),
		.i_rst_n     (i_rst_n),
		.req_valid_i (req_valid),
		.req_i       (req),
		.ack_o       (ack),
		.done_o      (done),
		.rd_data_o   (rd_data),
		.spi_so_i    (spi_so_i),
		.spi_sck_o   (spi_sck_o),
		.spi_ssn_o   (spi_ssn_o),
		.spi_si_o    (spi_si_o)
	);

	tdc_cfg_regs tdc_cfg_regs_i (
		.clk     (clk),
		.i_rst_n (i_rst_n),
		.we_i    (cfg_we_i),
		.waddr_i (cfg_addr_i),
		.wdata_i (cfg_wdata_i),
		.raddr_i (cfg_idx),
		.rdata_o (cfg_word)
	);

	tdc_result_fifo #(
		.T_ENTRY (tdc_result_t)
	) tdc_result_fifo_i (
		.clk         (clk),
		.i_rst_n     (i_rst_n),
		.push_i      (push),
		.push_data_i (push_data),
		.pop_i       (result_pop_i),
		.pop_data_o  (result_o),
		.not_empty_o (result_valid_o),
		.overflow_o  (overflow_o)
	);

endmodule

`default_nettype wire

// File: tests/tdc_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tdc_clk_gen #(
	parameter int HALF_PERIOD_NS = 20
) (
	output logic clk_o
);

	initial clk_o = 1'b0;

	always #(HALF_PERIOD_NS) clk_o = ~clk_o; // 40 ns period

endmodule

`default_nettype wire

// File: tests/tdc_slave_model.sv
`timescale 1ns/1ps
`default_nettype none

module tdc_slave_model (
	input  wire         clk,
	input  wire         meas_i,
	input  wire         spi_sck_i,
	input  wire         spi_ssn_i,
	input  wire         spi_si_i,
	output logic        spi_so_o = 1'b0,
	output logic        tdc_intn_o,
	output logic [31:0] frame_cnt_o = '0,
	output logic [7:0]  frame_op_o = '0,
	output logic [7:0]  frame_bits_o = '0,
	output logic [31:0] frame_wdata_o = '0
);

	logic [31:0] lcg_state = 32'h1a3871de;
	logic [7:0] op = '0;
	logic [31:0] wd = '0;
	logic [23:0] rd_val = '0;
	logic is_read = 1'b0;
	int nbits = 0;
	int meas_cnt = 0;
	int rd_cnt = 0;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Interrupt stays low until the chip sees the read opcode
	assign tdc_intn_o = (meas_cnt == rd_cnt);

	always @(posedge clk) begin
		if (meas_i)
			meas_cnt <= meas_cnt + 1;
	end

	always @(negedge spi_sck_i or posedge spi_ssn_i) begin
		if (spi_ssn_i === 1'b1) begin
			if (nbits > 0) begin
				frame_op_o    = op;
				frame_bits_o  = 8'(nbits);
				frame_wdata_o = wd;
				frame_cnt_o   = frame_cnt_o + 1; // Last, so fields are ready
			end
			nbits   = 0;
			op      = '0;
			wd      = '0;
			is_read = 1'b0;
		end else if (spi_ssn_i === 1'b0) begin
			if (nbits < 8)
				op = {op[6:0], spi_si_i};
			else
				wd = {wd[30:0], spi_si_i};
			nbits = nbits + 1;
			if (nbits == 8 && op == 8'hB0) begin
				lcg_state = lcg_next(lcg_state);
				rd_val    = lcg_state[31:8];
				is_read   = 1'b1;
				rd_cnt    = rd_cnt + 1;
			end
		end
	end

	// Data out after the rising edge, master samples on the fall
	always @(posedge spi_sck_i) begin
		if (spi_ssn_i === 1'b0 && is_read && nbits >= 8 && nbits < 32)
			spi_so_o <= rd_val[31 - nbits];
	end

endmodule

`default_nettype wire

// File: tests/tdc_frontend_tb.sv
`timescale 1ns/1ps
`default_nettype none

module tdc_frontend_tb;
	import tdc_pkg::*;

	logic clk;
	logic i_rst_n, start_i, cfg_we_i, result_pop_i, meas;
	logic [CFG_ADDR_W-1:0] cfg_addr_i;
	logic [TDC_WORD_W-1:0] cfg_wdata_i;
	tdc_result_t result_o;
	logic result_valid_o, overflow_o, busy_o;
	wire spi_sck_o, spi_ssn_o, spi_si_o, spi_so, tdc_intn;
	logic [31:0] frame_cnt, frame_wdata;
	logic [7:0] frame_op, frame_bits;

	logic [47:0] exp_frames [$]; // {bits, opcode, write word}
	tdc_result_t exp_results [$];
	logic [47:0] ef;
	tdc_result_t er;
	logic [31:0] exp_lcg = 32'h1a3871de;
	logic [7:0] exp_seq;
	logic exp_ovf;
	logic [31:0] frames_seen = '0;

	tdc_clk_gen clk_gen_i (.clk_o(clk));

	tdc_slave_model slave_i (
		.clk(clk), .meas_i(meas), .spi_sck_i(spi_sck_o), .spi_ssn_i(spi_ssn_o),
		.spi_si_i(spi_si_o), .spi_so_o(spi_so), .tdc_intn_o(tdc_intn),
		.frame_cnt_o(frame_cnt), .frame_op_o(frame_op), .frame_bits_o(frame_bits),
		.frame_wdata_o(frame_wdata)
	);

	tdc_frontend_top tdc_frontend_top_i (
		.clk(clk), .i_rst_n(i_rst_n), .start_i(start_i), .cfg_we_i(cfg_we_i),
		.cfg_addr_i(cfg_addr_i), .cfg_wdata_i(cfg_wdata_i), .result_pop_i(result_pop_i),
		.result_o(result_o), .result_valid_o(result_valid_o), .overflow_o(overflow_o),
		.busy_o(busy_o), .spi_sck_o(spi_sck_o), .spi_ssn_o(spi_ssn_o), .spi_si_o(spi_si_o),
		.spi_so_i(spi_so), .tdc_intn_i(tdc_intn)
	);

	task automatic check_hex(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			$display("ERR %s got %h expected %h", name, got, exp);
			$display("sim failed");
			$fatal(1);
		end
	endtask

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("sim failed");
		$fatal(1);
	endtask

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Expected frames and FIFO entries for each step
	function automatic void expect_arm(input logic [31:0] w0, w1, w2);
		exp_frames.push_back({8'd8, OP_POWER_ON_RESET, 32'h0});
		exp_frames.push_back({8'd40, OP_WRITE_CFG_BASE + 8'd0, w0});
		exp_frames.push_back({8'd40, OP_WRITE_CFG_BASE + 8'd1, w1});
		exp_frames.push_back({8'd40, OP_WRITE_CFG_BASE + 8'd2, w2});
		exp_frames.push_back({8'd8, OP_INIT, 32'h0});
	endfunction

	function automatic void expect_readout();
		exp_frames.push_back({8'd32, OP_READ_RESULT, 32'h0});
		exp_frames.push_back({8'd8, OP_INIT, 32'h0});
		exp_lcg = lcg_next(exp_lcg);
		if (exp_results.size() < RESULT_FIFO_DEPTH)
			exp_results.push_back('{seq: exp_seq, value: exp_lcg[31:8]});
		else
			exp_ovf = 1'b1; // Full FIFO drops the entry
		exp_seq = exp_seq + 1'b1;
	endfunction

	// Frame comparison
	always @(negedge clk) begin
		if (frame_cnt != frames_seen) begin
			frames_seen = frame_cnt;
			if (exp_frames.size() == 0)
				abort_run("frame seen on SPI while none was expected");
			ef = exp_frames.pop_front();
			check_hex("frame_bits", 32'(frame_bits), 32'(ef[47:40]));
			check_hex("frame_op", 32'(frame_op), 32'(ef[39:32]));
			check_hex("frame_wdata", frame_wdata, ef[31:0]);
			check_hex("busy_o", 32'(busy_o), 32'h1); // Frames only while arming or reading
		end
	end

	// Popped result comparison
	always @(posedge clk) begin
		if (result_pop_i && result_valid_o) begin
			if (exp_results.size() == 0)
				abort_run("result popped while none was expected");
			er = exp_results.pop_front();
			check_hex("result_o.seq", 32'(result_o.seq), 32'(er.seq));
			check_hex("result_o.value", 32'(result_o.value), 32'(er.value));
		end
	end

	task automatic reset_dut();
		i_rst_n = 1'b0;
		exp_seq = '0;
		exp_ovf = 1'b0;
		exp_results.delete();
		repeat (10) @(negedge clk);
		i_rst_n = 1'b1;
	endtask

	task automatic pulse(ref logic sig);
		@(negedge clk);
		sig = 1'b1;
		@(negedge clk);
		sig = 1'b0;
	endtask

	task automatic cfg_write(input logic [CFG_ADDR_W-1:0] a, input logic [31:0] d);
		@(negedge clk);
		cfg_we_i = 1'b1;
		cfg_addr_i = a;
		cfg_wdata_i = d;
		@(negedge clk);
		cfg_we_i = 1'b0;
	endtask

	task automatic wait_idle();
		int n;
		n = 0;
		while (exp_frames.size() != 0 || busy_o) begin
			@(negedge clk);
			n++;
			if (n > 2000)
				abort_run("timeout waiting for the frame sequence to finish");
		end
	endtask

	task automatic pop_one();
		int n;
		n = 0;
		while (!result_valid_o) begin
			@(negedge clk);
			n++;
			if (n > 200)
				abort_run("timeout waiting for result_valid_o");
		end
		pulse(result_pop_i);
	endtask

	initial begin
		i_rst_n = 1'b0;
		start_i = 1'b0;
		cfg_we_i = 1'b0;
		cfg_addr_i = '0;
		cfg_wdata_i = '0;
		result_pop_i = 1'b0;
		meas = 1'b0;
		reset_dut();
		check_hex("spi_ssn_o", 32'(spi_ssn_o), 32'h1);
		check_hex("spi_sck_o", 32'(spi_sck_o), 32'h0);
		check_hex("busy_o", 32'(busy_o), 32'h0);
		check_hex("result_valid_o", 32'(result_valid_o), 32'h0);
		check_hex("overflow_o", 32'(overflow_o), 32'h0);
		expect_arm(CFG_RESET_VALUES[0], CFG_RESET_VALUES[1], CFG_RESET_VALUES[2]);
		pulse(start_i);
		wait_idle();
		// Host values replace two reset words
		reset_dut();
		cfg_write(2'd0, 32'h1234_5678);
		cfg_write(2'd2, 32'h9abc_def0);
		expect_arm(32'h1234_5678, CFG_RESET_VALUES[1], 32'h9abc_def0);
		pulse(start_i);
		wait_idle();
		expect_readout();
		pulse(meas);
		wait_idle();
		pop_one();
		repeat (RESULT_FIFO_DEPTH + 2) begin
			expect_readout();
			pulse(meas);
			wait_idle();
			check_hex("overflow_o", 32'(overflow_o), 32'(exp_ovf)); // Set only once full
		end
		repeat (RESULT_FIFO_DEPTH) pop_one();
		@(negedge clk);
		check_hex("result_valid_o", 32'(result_valid_o), 32'h0);
		if (exp_frames.size() == 0 && exp_results.size() == 0) begin
			$display("sim passed");
			$finish;
		end else begin
			$display("expected frames or results were never seen");
			$display("sim failed");
			$fatal(1);
		end
	end

endmodule

`default_nettype wire

// File: filelist.f
common/tdc_pkg.sv
tdc_spi/tdc_spi_master.sv
design/tdc_cfg_regs.sv
design/tdc_result_fifo.sv
design/tdc_seq_ctrl.sv
design/tdc_frontend_top.sv
tests/tdc_clk_gen.sv
tests/tdc_slave_model.sv
tests/tdc_frontend_tb.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert
TOP      := tdc_frontend_tb
FILELIST := filelist.f
LOG      := sim.log
OBJDIR   := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "sim failed" $(LOG); then echo "FAIL"; exit 1; fi
	@if ! grep -q "sim passed" $(LOG); then echo "FAIL"; exit 1; fi
	@echo "PASS"

lint:
	$(SIM) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)
